//--- design/eager_fork.sv
//--------------------
// two-output eager fork, one owed flag per output
//--------------------
`default_nettype none

module eager_fork
	import elastic_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  word_t in_data,
	input  logic  in_valid,
	output logic  in_ready,
	output word_t out0_data,
	output word_t out1_data,
	output logic  out0_valid,
	output logic  out1_valid,
	input  logic  out0_ready,
	input  logic  out1_ready
);

	// bit set while that output still has to take the current token
	logic [1:0] owed;
	logic [1:0] out_valid_v;
	logic [1:0] out_ready_v;
	// accepted now or in an earlier cycle
	logic [1:0] done;
	logic       in_xfer;

	assign out_ready_v = {out1_ready, out0_ready};
	assign out_valid_v = {2{in_valid}} & owed;
	assign done        = ~owed | out_ready_v;

	// input leaves once every output has its copy
	assign in_ready = &done;
	assign in_xfer  = in_valid & in_ready;

	//--------------------
	// owed flags
	//--------------------

	// early acceptor clears its flag, all reload on the input transfer
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			owed <= 2'b11;
		end else if (in_xfer) begin
			owed <= 2'b11;
		end else begin
			owed <= owed & ~(out_valid_v & out_ready_v);
		end
	end

	// same word on both sides
	assign out0_data  = in_data;
	assign out1_data  = in_data;
	assign out0_valid = out_valid_v[0];
	assign out1_valid = out_valid_v[1];

endmodule

`default_nettype wire

//--- design/elastic_fifo.sv
//--------------------
// circular fifo with head and tail pointers
// registered full and empty flags
//--------------------
`default_nettype none

module elastic_fifo
	import elastic_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  word_t in_data,
	input  logic  in_valid,
	output logic  in_ready,
	output word_t out_data,
	output logic  out_valid,
	input  logic  out_ready
);

	// exactly FIFO_DEPTH entries
	word_t                mem [FIFO_DEPTH];
	// head reads, tail writes
	logic [PTR_WIDTH-1:0] head;
	logic [PTR_WIDTH-1:0] tail;
	logic                 full;
	logic                 empty;
	logic                 wr_en;
	logic                 rd_en;

	// wrap at the last entry, works for any depth
	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_WIDTH'(1);
	endfunction

	//--------------------
	// handshake
	//--------------------

	// a full fifo still takes a word when it is read in the same cycle
	assign in_ready  = ~full | out_ready;
	assign out_valid = ~empty;
	assign out_data  = mem[head];

	assign wr_en = in_valid & in_ready;
	assign rd_en = out_valid & out_ready;

	//--------------------
	// storage
	//--------------------

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[tail] <= in_data;
		end
	end

	//--------------------
	// pointers
	//--------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tail <= '0;
		end else if (wr_en) begin
			tail <= next_ptr(tail);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			head <= '0;
		end else if (rd_en) begin
			head <= next_ptr(head);
		end
	end

	//--------------------
	// flags
	//--------------------

	// only a lone write can fill, only a lone read can empty
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			full <= 1'b0;
		end else if (wr_en && !rd_en) begin
			if (next_ptr(tail) == head) begin
				full <= 1'b1;
			end
		end else if (rd_en && !wr_en) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			empty <= 1'b1;
		end else if (rd_en && !wr_en) begin
			if (next_ptr(head) == tail) begin
				empty <= 1'b1;
			end
		end else if (wr_en && !rd_en) begin
			empty <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- design/elastic_pkg.sv
//--------------------
// shared widths, depths and the token type
// for the elastic fork pipeline
//--------------------
`default_nettype none

package elastic_pkg;

	//--------------------
	// token
	//--------------------

	// payload width of every channel
	localparam int DATA_WIDTH = 16;

	// one token as it moves on a channel
	typedef logic [DATA_WIDTH-1:0] word_t;

	//--------------------
	// b-side fifo
	//--------------------

	// entries in the b-side circular fifo
	localparam int FIFO_DEPTH = 8;

	// head and tail pointer width
	localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

	// most tokens that can sit between input and output b
	// fifo entries plus one per half-buffer on that path
	localparam int SLACK_B = FIFO_DEPTH + 3;

endpackage

`default_nettype wire

//--- design/fork_pipeline_top.sv
//--------------------
// elastic buffer, eager fork and b-side fifo path
//--------------------
`default_nettype none

module fork_pipeline_top
	import elastic_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  word_t in_data,
	input  logic  in_valid,
	output logic  in_ready,
	output word_t a_data,
	output logic  a_valid,
	input  logic  a_ready,
	output word_t b_data,
	output logic  b_valid,
	input  logic  b_ready
);

	// input tehb to oehb
	word_t eb_mid_data;
	logic  eb_mid_valid;
	logic  eb_mid_ready;
	// oehb to fork
	word_t fork_in_data;
	logic  fork_in_valid;
	logic  fork_in_ready;
	// fork output 1 to b-side tehb
	word_t fork_b_data;
	logic  fork_b_valid;
	logic  fork_b_ready;
	// b-side tehb to fifo
	word_t fifo_in_data;
	logic  fifo_in_valid;
	logic  fifo_in_ready;

	//--------------------
	// full elastic buffer
	//--------------------

	tehb u_in_tehb (
		.clk      (clk),
		.rst      (rst),
		.in_data  (in_data),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.out_data (eb_mid_data),
		.out_valid(eb_mid_valid),
		.out_ready(eb_mid_ready)
	);

	oehb u_in_oehb (
		.clk      (clk),
		.rst      (rst),
		.in_data  (eb_mid_data),
		.in_valid (eb_mid_valid),
		.in_ready (eb_mid_ready),
		.out_data (fork_in_data),
		.out_valid(fork_in_valid),
		.out_ready(fork_in_ready)
	);

	//--------------------
	// fork, output 0 is channel a
	//--------------------

	eager_fork u_fork (
		.clk       (clk),
		.rst       (rst),
		.in_data   (fork_in_data),
		.in_valid  (fork_in_valid),
		.in_ready  (fork_in_ready),
		.out0_data (a_data),
		.out1_data (fork_b_data),
		.out0_valid(a_valid),
		.out1_valid(fork_b_valid),
		.out0_ready(a_ready),
		.out1_ready(fork_b_ready)
	);

	//--------------------
	// b side, lets b lag a
	//--------------------

	tehb u_b_tehb (
		.clk      (clk),
		.rst      (rst),
		.in_data  (fork_b_data),
		.in_valid (fork_b_valid),
		.in_ready (fork_b_ready),
		.out_data (fifo_in_data),
		.out_valid(fifo_in_valid),
		.out_ready(fifo_in_ready)
	);

	elastic_fifo u_b_fifo (
		.clk      (clk),
		.rst      (rst),
		.in_data  (fifo_in_data),
		.in_valid (fifo_in_valid),
		.in_ready (fifo_in_ready),
		.out_data (b_data),
		.out_valid(b_valid),
		.out_ready(b_ready)
	);

endmodule

`default_nettype wire

//--- design/oehb.sv
//--------------------
// opaque half-buffer, registered data and valid
//--------------------
`default_nettype none

module oehb
	import elastic_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  word_t in_data,
	input  logic  in_valid,
	output logic  in_ready,
	output word_t out_data,
	output logic  out_valid,
	input  logic  out_ready
);

	logic  valid_q;
	word_t data_q;

	// take a new token when empty or when the current one leaves
	assign in_ready = ~valid_q | out_ready;

	// valid register breaks the forward valid path
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
	end

	// payload only moves on an input transfer
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	assign out_valid = valid_q;
	assign out_data  = data_q;

endmodule

`default_nettype wire

//--- design/tehb.sv
//--------------------
// transparent half-buffer with one skid register
//--------------------
`default_nettype none

module tehb
	import elastic_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  word_t in_data,
	input  logic  in_valid,
	output logic  in_ready,
	output word_t out_data,
	output logic  out_valid,
	input  logic  out_ready
);

	// low only in the first cycle after reset
	logic  armed;
	// skid register holds a token
	logic  full;
	word_t skid_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			armed <= 1'b0;
		end else begin
			armed <= 1'b1;
		end
	end

	// full while a presented token is stalled
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			full <= 1'b0;
		end else begin
			full <= out_valid & ~out_ready;
		end
	end

	// catch the incoming token on a downstream stall
	always_ff @(posedge clk) begin
		if (in_valid && in_ready && !out_ready) begin
			skid_q <= in_data;
		end
	end

	assign in_ready  = armed & ~full;
	// pass-through while empty
	assign out_valid = full | (in_valid & armed);
	assign out_data  = full ? skid_q : in_data;

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the fork pipeline testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -j 0 \
	--top-module fork_pipeline_tb -Mdir obj_dir -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

# let assertion errors through so the testbench summary still prints
output=$(./obj_dir/Vfork_pipeline_tb +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

//--- test/fork_pipeline_sva.sv
//--------------------
// channel stability and post-reset checks
// bound into the pipeline top level
//--------------------
`default_nettype none

module fork_pipeline_sva
	import elastic_pkg::*;
(
	input logic  clk,
	input logic  rst,
	// top-level channels
	input word_t in_data, a_data, b_data,
	input logic  in_valid, a_valid, b_valid,
	input logic  in_ready, a_ready, b_ready,
	// internal channels
	input word_t eb_mid_data, fork_in_data, fork_b_data, fifo_in_data,
	input logic  eb_mid_valid, fork_in_valid, fork_b_valid, fifo_in_valid,
	input logic  eb_mid_ready, fork_in_ready, fork_b_ready, fifo_in_ready
);

	timeunit 1ns;
	timeprecision 1ps;

	// failures seen, read by the testbench summary
	int fail_count = 0;

	// 7 input, 6 tehb-oehb, 5 fork in, 4 a, 3 fork b, 2 fifo in, 1 b
	logic [7:1]                 chan_valid;
	logic [7:1]                 chan_ready;
	logic [7:1][DATA_WIDTH-1:0] chan_data;

	assign chan_valid = {in_valid, eb_mid_valid, fork_in_valid, a_valid,
		fork_b_valid, fifo_in_valid, b_valid};
	assign chan_ready = {in_ready, eb_mid_ready, fork_in_ready, a_ready,
		fork_b_ready, fifo_in_ready, b_ready};
	assign chan_data = {in_data, eb_mid_data, fork_in_data, a_data,
		fork_b_data, fifo_in_data, b_data};

	// stalled token keeps valid and data
	for (genvar i = 1; i < 8; i++) begin : g_hold
		hold_a: assert property (@(posedge clk) disable iff (rst)
			chan_valid[i] && !chan_ready[i] |=> chan_valid[i] && $stable(chan_data[i]))
		else begin
			fail_count++;
			$error("stalled token changed on channel %0d", i);
		end
	end

	// both outputs empty in the first cycle out of reset
	reset_empty_a: assert property (@(posedge clk) $fell(rst) |-> !a_valid && !b_valid)
	else begin
		fail_count++;
		$error("output valid in the cycle after reset release");
	end

endmodule

`default_nettype wire

//--- test/fork_pipeline_tb.sv
//--------------------
// testbench for the elastic fork pipeline
// random stimulus, one queue model per output, timeout
//--------------------
`default_nettype none

module fork_pipeline_tb
	import elastic_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	//--------------------
	// run constants
	//--------------------

	localparam int SEED          = 23893;
	// tokens an a-side stall may let in
	localparam int SLACK_A       = 3;
	localparam int TOKENS_FREE   = 100;
	localparam int TOKENS_RANDOM = 300;
	localparam int TOKENS_HELD   = 40;
	// cycles in_ready must stay low to count as stalled
	localparam int LOW_RUN       = 20;
	localparam int CYCLE_LIMIT   = (TOKENS_FREE + TOKENS_RANDOM + 2 * TOKENS_HELD) * 20;

	logic  clk;
	logic  rst;
	word_t in_data;
	logic  in_valid;
	logic  in_ready;
	word_t a_data;
	logic  a_valid;
	logic  a_ready;
	word_t b_data;
	logic  b_valid;
	logic  b_ready;

	// expected tokens, pushed on input transfer, popped on output transfer
	word_t q_a[$];
	word_t q_b[$];

	int   cycles = 0;
	int   checks = 0;
	int   errors = 0;
	int   tests = 0;
	int   test_errors;
	int   accepted;
	// no new token once accepted reaches this
	int   target;
	// percent chances per cycle
	int   p_valid;
	int   p_a;
	int   p_b;
	int   wait_cnt;
	int   low_run;
	logic in_xfer_seen = 1'b0;

	fork_pipeline_top dut_i (.*);

	bind fork_pipeline_top fork_pipeline_sva sva_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycles <= cycles + 1;

	initial begin
		wait (cycles >= CYCLE_LIMIT);
		$display("timeout: run passed %0d cycles", cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	//--------------------
	// helpers
	//--------------------

	function automatic logic chance(input int pct);
		return int'($urandom % 100) < pct;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("error: %s", msg);
	endtask

	// drive on the rising edge, observe handshakes at the falling edge
	task automatic step();
		logic in_xfer;
		logic a_xfer;
		logic b_xfer;
		@(posedge clk);
		// a stalled token keeps valid and data
		if (!(in_valid && !in_xfer_seen)) begin
			if (accepted < target && chance(p_valid)) begin
				in_valid <= 1'b1;
				in_data  <= word_t'($urandom);
			end else begin
				in_valid <= 1'b0;
			end
		end
		a_ready <= chance(p_a);
		b_ready <= chance(p_b);
		@(negedge clk);
		in_xfer = in_valid & in_ready;
		a_xfer  = a_valid & a_ready;
		b_xfer  = b_valid & b_ready;
		if (a_xfer) begin
			if (q_a.size() == 0) begin
				report_error("token on output a that was never accepted");
			end else begin
				check_word("a_data", a_data, q_a.pop_front());
			end
		end
		if (b_xfer) begin
			if (q_b.size() == 0) begin
				report_error("token on output b that was never accepted");
			end else begin
				check_word("b_data", b_data, q_b.pop_front());
			end
		end
		// same word owed to both outputs
		if (in_xfer) begin
			q_a.push_back(in_data);
			q_b.push_back(in_data);
			accepted++;
		end
		in_xfer_seen = in_xfer;
	endtask

	// stop new tokens, run until both models are empty
	task automatic drain();
		target = accepted;
		while ((in_valid && !in_xfer_seen) || q_a.size() > 0 || q_b.size() > 0) begin
			step();
		end
		// last output transfer leaves on this edge
		step();
		check_bit("a_valid", a_valid, 1'b0);
		check_bit("b_valid", b_valid, 1'b0);
	endtask

	task automatic start_test();
		tests++;
		test_errors = errors;
		accepted = 0;
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d tokens, %0d errors", name, accepted, errors - test_errors);
	endtask

	//--------------------
	// test sequence
	//--------------------

	initial begin
		void'($urandom(SEED));
		rst      = 1'b1;
		in_data  = '0;
		in_valid = 1'b0;
		a_ready  = 1'b0;
		b_ready  = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		// stage empty and input closed right after reset
		start_test();
		@(negedge clk);
		check_bit("in_ready", in_ready, 1'b0);
		check_bit("a_valid", a_valid, 1'b0);
		check_bit("b_valid", b_valid, 1'b0);
		p_valid = 0;
		p_a = 100;
		p_b = 100;
		target = 0;
		wait_cnt = 0;
		while (!in_ready && wait_cnt < 4) begin
			step();
			wait_cnt++;
		end
		if (!in_ready) begin
			report_error("in_ready did not rise after reset");
		end
		end_test("reset");

		start_test();
		p_valid = 70;
		target = TOKENS_FREE;
		while (accepted < target) step();
		drain();
		end_test("free flow");

		// independent consumer stalls
		start_test();
		p_valid = 60;
		p_a = 55;
		p_b = 30;
		target = TOKENS_RANDOM;
		while (accepted < target) step();
		drain();
		end_test("random stalls");

		// b held off until the input closes for good
		start_test();
		p_valid = 100;
		p_a = 100;
		p_b = 0;
		target = TOKENS_HELD;
		low_run = 0;
		while (low_run < LOW_RUN) begin
			step();
			low_run = (in_valid && !in_ready) ? low_run + 1 : 0;
		end
		if (accepted > SLACK_B) begin
			report_error("more tokens accepted than the b path can hold");
		end
		p_b = 100;
		drain();
		end_test("b held off");

		// a held off
		start_test();
		p_a = 0;
		target = TOKENS_HELD;
		repeat (LOW_RUN) step();
		if (accepted > SLACK_A) begin
			report_error("more tokens accepted than the a path can hold");
		end
		p_a = 100;
		drain();
		end_test("a held off");

		if (dut_i.sva_i.fail_count != 0) begin
			report_error("bound assertions failed");
		end
		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
design/elastic_pkg.sv
design/tehb.sv
design/oehb.sv
design/elastic_fifo.sv
design/eager_fork.sv
design/fork_pipeline_top.sv
test/fork_pipeline_sva.sv
test/fork_pipeline_tb.sv
